//--- rtl/noc_route_pkg.sv
// shared mesh sizes, port numbering and request types for the look-ahead route stage
package noc_route_pkg;

    // mesh dimensions, 4x4 routers
    localparam int mesh_nx = 4;
    localparam int mesh_ny = 4;

    // address field widths
    localparam int x_w = 2;
    localparam int y_w = 2;

    // router ports
    localparam int port_num   = 5;
    localparam int port_bin_w = 3;  // binary port number
    localparam int enc_port_w = 4;  // port vector with one port taken out

    // router port numbers
    // north lowers y, south raises y
    typedef enum logic [port_bin_w-1:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    // router coordinates
    typedef logic [x_w-1:0] x_addr_t;
    typedef logic [y_w-1:0] y_addr_t;

    typedef struct packed {
        x_addr_t x;
        y_addr_t y;
    } node_addr_t;

    // one-hot over all five ports, bit index is the port_e value
    typedef logic [port_num-1:0] port_onehot_t;

    // one-hot over the four ports left once one port is dropped
    // the dropped port closes the gap, higher ports shift down by one
    typedef logic [enc_port_w-1:0] port_enc_t;

    // request seen by one router input port
    typedef struct packed {
        node_addr_t dest;       // final destination router
        port_enc_t  dest_port;  // output port picked at this router
    } route_req_t;

endpackage

//--- rtl/next_hop_predictor.sv
// predicts next router address and its receiving port from the encoded output port
`timescale 1ns/1ns

module next_hop_predictor
    import noc_route_pkg::*;
#(
    parameter int sw_loc = 0  // port number of the input port holding this stage
) (
    input  port_enc_t    dest_port,
    input  node_addr_t   current_addr,
    output node_addr_t   next_addr,
    output port_onehot_t rx_port
);

    localparam x_addr_t last_x = x_addr_t'(mesh_nx - 1);
    localparam y_addr_t last_y = y_addr_t'(mesh_ny - 1);

    port_onehot_t dest_onehot;  // dest_port expanded to five ports

    // put back the hole at sw_loc, a packet never leaves on the port it came in
    for (genvar i = 0; i < port_num; i++) begin : g_expand
        if (i < sw_loc) begin : g_below
            assign dest_onehot[i] = dest_port[i];
        end else if (i == sw_loc) begin : g_self
            assign dest_onehot[i] = 1'b0;
        end else begin : g_above
            assign dest_onehot[i] = dest_port[i-1];
        end
    end

    // one hop in the chosen direction
    always_comb begin
        next_addr = current_addr;  // local or nothing selected
        if (dest_onehot[port_east]) begin
            next_addr.x = (current_addr.x == last_x) ? '0 : current_addr.x + 1'b1;
        end else if (dest_onehot[port_north]) begin
            next_addr.y = (current_addr.y == '0) ? last_y : current_addr.y - 1'b1;
        end else if (dest_onehot[port_west]) begin
            next_addr.x = (current_addr.x == '0) ? last_x : current_addr.x - 1'b1;
        end else if (dest_onehot[port_south]) begin
            next_addr.y = (current_addr.y == last_y) ? '0 : current_addr.y + 1'b1;
        end
    end

    // next router sees the packet on the opposite side
    always_comb begin
        rx_port             = '0;
        rx_port[port_local] = dest_onehot[port_local];
        rx_port[port_west]  = dest_onehot[port_east];
        rx_port[port_east]  = dest_onehot[port_west];
        rx_port[port_north] = dest_onehot[port_south];
        rx_port[port_south] = dest_onehot[port_north];
    end

endmodule

//--- rtl/xy_route.sv
// deterministic XY routing at a given router, one-hot output port
`timescale 1ns/1ns

module xy_route
    import noc_route_pkg::*;
(
    input  node_addr_t   cur_addr,
    input  node_addr_t   dest_addr,
    output port_onehot_t port
);

    // x first, then y once the column matches
    always_comb begin
        port = '0;
        if (dest_addr.x > cur_addr.x) begin
            port[port_east] = 1'b1;
        end else if (dest_addr.x < cur_addr.x) begin
            port[port_west] = 1'b1;
        end else if (dest_addr.y > cur_addr.y) begin
            port[port_south] = 1'b1;  // south raises y
        end else if (dest_addr.y < cur_addr.y) begin
            port[port_north] = 1'b1;
        end else begin
            port[port_local] = 1'b1;  // arrived
        end
    end

endmodule

//--- rtl/receive_port_remover.sv
// drops the receiving port from a one-hot port vector, giving the 4-bit encoded port
`timescale 1ns/1ns

module receive_port_remover
    import noc_route_pkg::*;
(
    input  port_onehot_t port_in,
    input  port_onehot_t rx_port,
    output port_enc_t    port_out
);

    logic [port_bin_w-1:0] port_bin;
    logic [port_bin_w-1:0] rx_bin;
    logic [port_bin_w-1:0] out_bin;
    logic [$clog2(enc_port_w)-1:0] enc_bin;  // index into the 4-bit vector

    // OR of set bit indices, all zero gives 0
    function automatic logic [port_bin_w-1:0] onehot_to_bin(input port_onehot_t vec);
        logic [port_bin_w-1:0] bin;
        bin = '0;
        for (int i = 0; i < port_num; i++) begin
            if (vec[i]) begin
                bin = bin | port_bin_w'(i);
            end
        end
        return bin;
    endfunction

    assign port_bin = onehot_to_bin(port_in);
    assign rx_bin   = onehot_to_bin(rx_port);

    // ports above the receiving one move down a place
    always_comb begin
        if (rx_bin > port_bin) begin
            out_bin = port_bin;
        end else begin
            out_bin = port_bin - 1'b1;
        end
    end

    // local with no receive port wraps to the top bit
    assign enc_bin = out_bin[$clog2(enc_port_w)-1:0];

    always_comb begin
        port_out          = '0;
        port_out[enc_bin] = 1'b1;
    end

endmodule

//--- rtl/lookahead_route.sv
// look-ahead route stage for one router input port, registers the request and routes ahead
`timescale 1ns/1ns

module lookahead_route
    import noc_route_pkg::*;
#(
    parameter int sw_loc = 0  // port number of this input port, 0 to 4
) (
    input  logic       clk,
    input  logic       reset,
    input  node_addr_t current_addr,  // this router, static level
    input  route_req_t req,
    output port_enc_t  lk_port        // output port to use at the next router
);

    route_req_t   req_q;
    node_addr_t   next_addr;
    port_onehot_t rx_port;
    port_onehot_t next_port;  // next router's XY choice, receiving port still in

    // new request every cycle, no handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    // where the packet lands and on which side
    next_hop_predictor #(
        .sw_loc (sw_loc)
    ) u_next_hop (
        .dest_port    (req_q.dest_port),
        .current_addr (current_addr),
        .next_addr    (next_addr),
        .rx_port      (rx_port)
    );

    // route as the next router would
    xy_route u_xy_route (
        .cur_addr  (next_addr),
        .dest_addr (req_q.dest),
        .port      (next_port)
    );

    // encode relative to the next router's receiving port
    receive_port_remover u_rx_remove (
        .port_in  (next_port),
        .rx_port  (rx_port),
        .port_out (lk_port)
    );

endmodule

//--- sim/lookahead_route_props.sv
// concurrent checks on the look-ahead route stage, bound into every lookahead_route instance
`timescale 1ns/1ns

module lookahead_route_props
    import noc_route_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input route_req_t req_q,
    input port_enc_t  lk_port
);

    // exactly one look-ahead port at all times
    a_lk_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(lk_port))
        else $error("lk_port is not one-hot");

    a_lk_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(lk_port))
        else $error("lk_port has unknown bits");

    // register still cleared on the first edge after reset
    a_req_clear: assert property (@(posedge clk) $fell(reset) |-> (req_q == '0))
        else $error("request register not clear after reset");

endmodule

bind lookahead_route lookahead_route_props u_props (
    .clk     (clk),
    .reset   (reset),
    .req_q   (req_q),
    .lk_port (lk_port)
);

//--- sim/tb_lookahead_route.sv
// testbench for lookahead_route that checks random requests against a model of XY look-ahead
`timescale 1ns/1ns

module tb_lookahead_route
    import noc_route_pkg::*;
;

    localparam int clk_period     = 100;
    localparam int sw_loc_tb      = 2;   // DUT sits on the north input port
    localparam int reset_cycles   = 3;
    localparam int reset_checks   = 8;
    localparam int arrival_checks = 50;
    localparam int random_checks  = 400;
    localparam int wrap_checks    = 64;  // upper bound of 16 addresses times 4 ports
    localparam int latency_checks = 10;
    localparam int test_cycles    = reset_cycles + 1 + reset_checks + arrival_checks
                                    + random_checks + wrap_checks + 2 * latency_checks;
    localparam int watchdog_ns    = (test_cycles + 50) * clk_period;

    logic       clk;
    logic       reset;
    node_addr_t current_addr;
    route_req_t req;
    port_enc_t  lk_port;

    route_req_t model_q;  // request the model expects in the DUT register
    int         seed;

    lookahead_route #(
        .sw_loc (sw_loc_tb)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .current_addr (current_addr),
        .req          (req),
        .lk_port      (lk_port)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // model of the request register
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model_q <= '0;
        end else begin
            model_q <= req;
        end
    end

    // encoded bit back to a router port number (-1 when nothing is set)
    function automatic int sel_port(input port_enc_t dp);
        int sel;
        sel = -1;
        for (int i = 0; i < enc_port_w; i++) begin
            if (dp[i]) begin
                sel = (i < sw_loc_tb) ? i : i + 1;  // the hole sits at sw_loc
            end
        end
        return sel;
    endfunction

    // port on which the next router receives (0 when no port is chosen)
    function automatic int opposite(input int p);
        case (p)
            int'(port_east):  return int'(port_west);
            int'(port_west):  return int'(port_east);
            int'(port_north): return int'(port_south);
            int'(port_south): return int'(port_north);
            default:          return 0;
        endcase
    endfunction

    function automatic node_addr_t step_addr(input node_addr_t a, input int p);
        int         x;
        int         y;
        node_addr_t n;
        x = int'(a.x);
        y = int'(a.y);
        case (p)
            int'(port_east):  x = (x + 1) % mesh_nx;
            int'(port_west):  x = (x + mesh_nx - 1) % mesh_nx;
            int'(port_north): y = (y + mesh_ny - 1) % mesh_ny;  // north lowers y
            int'(port_south): y = (y + 1) % mesh_ny;
            default:          ;
        endcase
        n.x = x_addr_t'(x);
        n.y = y_addr_t'(y);
        return n;
    endfunction

    function automatic int xy_choice(input node_addr_t cur, input node_addr_t dst);
        if (dst.x > cur.x) return int'(port_east);
        if (dst.x < cur.x) return int'(port_west);
        if (dst.y > cur.y) return int'(port_south);
        if (dst.y < cur.y) return int'(port_north);
        return int'(port_local);
    endfunction

    function automatic port_enc_t drop_rx(input int p, input int rx);
        int res;
        res = (rx > p) ? p : p - 1;
        res = (res + 8) % 8;  // 3-bit port number so -1 becomes 7
        return port_enc_t'(4'b0001 << (res % enc_port_w));
    endfunction

    function automatic port_enc_t expected_lk(input route_req_t r, input node_addr_t a);
        int sel;
        sel = sel_port(r.dest_port);
        return drop_rx(xy_choice(step_addr(a, sel), r.dest), opposite(sel));
    endfunction

    // after reset the router routes XY towards (0,0) with receive number 0
    function automatic port_enc_t reset_lk(input node_addr_t a);
        node_addr_t origin;
        origin = '0;
        return drop_rx(xy_choice(a, origin), 0);
    endfunction

    task automatic check_value(input string test_name, input port_enc_t expected,
                               input port_enc_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", test_name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s gave a wrong lk_port", test_name);
        end
    endtask

    task automatic apply(input route_req_t r, input node_addr_t a);
        req          = r;
        current_addr = a;
    endtask

    // random encoded bit that may be kept off the local port
    task automatic pick_port_bit(output int k, input bit no_local);
        logic [31:0] r;
        r = $random(seed);
        k = int'(r[1:0]);
        if (no_local && sel_port(port_enc_t'(4'b0001 << k)) == int'(port_local)) begin
            k = (k + 1) % enc_port_w;
        end
    endtask

    task automatic random_req(output route_req_t rq, output node_addr_t a);
        logic [31:0] r;
        int          k;
        r = $random(seed);
        a = r[3:0];
        rq.dest = r[7:4];
        pick_port_bit(k, 1'b0);
        rq.dest_port = port_enc_t'(4'b0001 << k);
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout, the run did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        node_addr_t  a;
        route_req_t  ra;
        route_req_t  rb;
        int          k;
        int          p;
        seed         = 32'h75ff856f;
        reset        = 1'b1;
        random_req(ra, a);
        apply(ra, a);  // live request that the reset has to hold off
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        req   = '0;

        // only the router address moves while req stays zero
        for (int i = 0; i < reset_checks; i++) begin
            r = $random(seed);
            current_addr = r[3:0];
            @(negedge clk);
            check_value("reset_value", reset_lk(current_addr), lk_port);
        end

        // destination is the next router itself
        for (int i = 0; i < arrival_checks; i++) begin
            r = $random(seed);
            a = r[3:0];
            pick_port_bit(k, 1'b1);
            ra.dest_port = port_enc_t'(4'b0001 << k);
            ra.dest      = step_addr(a, sel_port(ra.dest_port));
            apply(ra, a);
            @(negedge clk);
            check_value("arrival", 4'b0001, lk_port);
        end

        for (int i = 0; i < random_checks; i++) begin
            random_req(ra, a);
            apply(ra, a);
            @(negedge clk);
            check_value("random", expected_lk(model_q, current_addr), lk_port);
        end

        // every outward hop at the mesh border
        for (int ax = 0; ax < mesh_nx; ax++) begin
            for (int ay = 0; ay < mesh_ny; ay++) begin
                for (int kk = 0; kk < enc_port_w; kk++) begin
                    p = sel_port(port_enc_t'(4'b0001 << kk));
                    if ((p == int'(port_east) && ax == mesh_nx - 1) ||
                        (p == int'(port_west) && ax == 0) ||
                        (p == int'(port_north) && ay == 0) ||
                        (p == int'(port_south) && ay == mesh_ny - 1)) begin
                        r = $random(seed);
                        a.x = x_addr_t'(ax);
                        a.y = y_addr_t'(ay);
                        ra.dest      = r[3:0];
                        ra.dest_port = port_enc_t'(4'b0001 << kk);
                        apply(ra, a);
                        @(negedge clk);
                        check_value("edge_wrap", expected_lk(ra, a), lk_port);
                    end
                end
            end
        end

        // old request must hold until the next rising edge
        for (int i = 0; i < latency_checks; i++) begin
            random_req(ra, a);
            apply(ra, a);
            @(negedge clk);
            check_value("latency_first", expected_lk(ra, a), lk_port);
            random_req(rb, current_addr);
            current_addr = a;
            for (int t = 0; t < 16 && expected_lk(rb, a) == expected_lk(ra, a); t++) begin
                random_req(rb, current_addr);
                current_addr = a;
            end
            req = rb;
            #(clk_period / 2 - 1);  // just ahead of the rising edge
            check_value("latency_hold", expected_lk(ra, a), lk_port);
            @(negedge clk);
            check_value("latency_update", expected_lk(rb, a), lk_port);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
rtl/noc_route_pkg.sv
rtl/next_hop_predictor.sv
rtl/xy_route.sv
rtl/receive_port_remover.sv
rtl/lookahead_route.sv
sim/lookahead_route_props.sv
sim/tb_lookahead_route.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the look-ahead route testbench with Verilator and runs it.
# The exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_lookahead_route \
    -f verilog.f \
    -o tb_lookahead_route_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_lookahead_route_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
